/* Bender.yml */
package:
  name: balance_cntrl

sources:
  - include_dirs:
      - design
    files:
      - design/balance_pkg.sv
      - design/pitch_pd_term.sv
      - design/pitch_integrator.sv
      - design/torque_mixer.sv
      - design/motor_shaper.sv
      - design/drive_output.sv
      - design/balance_cntrl.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/balance_checker.sv
      - testbench/balance_cntrl_tb.sv

/* balance_cntrl.f */
+incdir+design
design/balance_pkg.sv
design/pitch_pd_term.sv
design/pitch_integrator.sv
design/torque_mixer.sv
design/motor_shaper.sv
design/drive_output.sv
design/balance_cntrl.sv
testbench/balance_checker.sv
testbench/balance_cntrl_tb.sv

/* design/balance_cntrl.sv */
// balance controller top level
`timescale 1ns/1ps
`default_nettype none

module balance_cntrl
  import balance_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire               vld,            // new inertial reading
  input  wire signed [15:0] ptch,           // measured pitch
  input  wire signed [11:0] ld_cell_diff,   // left minus right load
  input  wire               rider_off,
  input  wire               en_steer,
  input  wire               pwr_up,
  output spd_t              lft_spd,
  output wire               lft_rev,
  output spd_t              rght_spd,
  output wire               rght_rev,
  output wire               ovr_spd
);

  ptch_err_t ptch_err;
  p_term_t   p_term;
  d_term_t   d_term;
  integ_t    integrator;
  torque_t   lft_torque;
  torque_t   rght_torque;
  torque_t   lft_shaped;
  torque_t   rght_shaped;

  ////////////////////////////////////////
  // PID front end
  ////////////////////////////////////////

  pitch_pd_term u_pd_term (
    .clk      (clk),
    .rst_n    (rst_n),
    .vld      (vld),
    .ptch     (ptch),
    .ptch_err (ptch_err),
    .p_term   (p_term),
    .d_term   (d_term)
  );

  pitch_integrator u_integrator (
    .clk        (clk),
    .rst_n      (rst_n),
    .vld        (vld),
    .ptch_err   (ptch_err),
    .rider_off  (rider_off),
    .pwr_up     (pwr_up),
    .integrator (integrator)
  );

  torque_mixer u_mixer (
    .p_term       (p_term),
    .d_term       (d_term),
    .integrator   (integrator),
    .ld_cell_diff (ld_cell_diff),
    .en_steer     (en_steer),
    .lft_torque   (lft_torque),
    .rght_torque  (rght_torque)
  );

  ////////////////////////////////////////
  // per wheel shaping and drive
  ////////////////////////////////////////

  motor_shaper u_lft_shaper (.clk(clk), .rst_n(rst_n), .torque(lft_torque), .shaped(lft_shaped));
  motor_shaper u_rght_shaper (.clk(clk), .rst_n(rst_n), .torque(rght_torque), .shaped(rght_shaped));

  drive_output u_drive (
    .lft_shaped  (lft_shaped),
    .rght_shaped (rght_shaped),
    .pwr_up      (pwr_up),
    .lft_spd     (lft_spd),
    .rght_spd    (rght_spd),
    .lft_rev     (lft_rev),
    .rght_rev    (rght_rev),
    .ovr_spd     (ovr_spd)
  );

endmodule

`default_nettype wire

/* design/balance_macros.svh */
// balance controller constants
`ifndef BALANCE_MACROS_SVH
`define BALANCE_MACROS_SVH

////////////////////////////////////////
// PID gains
////////////////////////////////////////

// proportional gain applied to the saturated pitch error
`define BAL_P_COEFF 14

// derivative gain applied to the saturated two-sample difference
`define BAL_D_COEFF 20

// integrator contributes integrator >>> this shift
`define BAL_INT_SHIFT 6

////////////////////////////////////////
// torque shaping
////////////////////////////////////////

`define BAL_LOW_TORQUE_BAND 70   // 5 * P gain, below this torque is gain scaled
`define BAL_GAIN_MULT 15         // 1 + min duty / low band, keeps the curve continuous
`define BAL_MIN_DUTY 980         // offset that stiffens the motor outside the low band

////////////////////////////////////////
// steering and speed limits
////////////////////////////////////////

`define BAL_STEER_SHIFT 3        // load cell difference is scaled down by 8
`define BAL_SPD_MAX 2047         // full scale of the 11 bit unsigned speed
`define BAL_WARN_SPD 1536        // above this the rider gets the over-speed warning

`endif

/* design/balance_pkg.sv */
// balance controller types
`default_nettype none

package balance_pkg;

  ////////////////////////////////////////
  // PID path
  ////////////////////////////////////////

  typedef logic signed [9:0]  ptch_err_t;  // pitch error, saturated to 10 bits
  typedef logic signed [14:0] p_term_t;    // 14 * 10 bit error fits in 15 bits
  typedef logic signed [12:0] d_term_t;    // 20 * 7 bit difference fits in 13 bits
  typedef logic signed [17:0] integ_t;     // running sum of the pitch error

  ////////////////////////////////////////
  // torque and drive
  ////////////////////////////////////////

  // control value, per-wheel torque and shaped drive all share 16 bits
  typedef logic signed [15:0] torque_t;

  // motor speed, magnitude only, direction travels separately
  typedef logic [10:0] spd_t;

endpackage

`default_nettype wire

/* design/drive_output.sv */
// motor speed and direction outputs
`timescale 1ns/1ps
`default_nettype none

`include "balance_macros.svh"

module drive_output
  import balance_pkg::*;
(
  input  torque_t lft_shaped,
  input  torque_t rght_shaped,
  input  wire     pwr_up,       // speeds held at zero while low
  output spd_t    lft_spd,
  output spd_t    rght_spd,
  output logic    lft_rev,      // 1 runs the left motor backwards
  output logic    rght_rev,
  output logic    ovr_spd       // drives the piezo warning
);

  localparam spd_t SPD_MAX  = `BAL_SPD_MAX;
  localparam spd_t WARN_SPD = `BAL_WARN_SPD;

  // magnitude of a shaped value, clipped to the 11 bit speed range
  function automatic spd_t sat_spd(input torque_t val);
    logic [15:0] mag;
    mag = val[15] ? -val : val;
    return (|mag[15:11]) ? SPD_MAX : mag[10:0];
  endfunction

  assign lft_rev  = lft_shaped[15];
  assign rght_rev = rght_shaped[15];

  assign lft_spd  = pwr_up ? sat_spd(lft_shaped) : '0;
  assign rght_spd = pwr_up ? sat_spd(rght_shaped) : '0;

  // a saturated speed always trips the warning
  assign ovr_spd = (lft_spd > WARN_SPD) || (rght_spd > WARN_SPD);

endmodule

`default_nettype wire

/* design/motor_shaper.sv */
// per wheel torque shaper
`timescale 1ns/1ps
`default_nettype none

`include "balance_macros.svh"

module motor_shaper
  import balance_pkg::*;
(
  input  wire     clk,
  input  wire     rst_n,
  input  torque_t torque,   // raw wheel torque from the mixer
  output torque_t shaped    // registered drive value
);

  localparam logic [15:0] LOW_BAND  = `BAL_LOW_TORQUE_BAND;
  localparam torque_t     GAIN_MULT = `BAL_GAIN_MULT;
  localparam torque_t     MIN_DUTY  = `BAL_MIN_DUTY;

  logic [15:0] torque_mag;   // unsigned magnitude
  torque_t     duty_offs;    // torque pushed away from zero
  torque_t     low_gain;     // torque scaled in the low band
  torque_t     shaped_nxt;

  assign torque_mag = torque[15] ? -torque : torque;

  assign duty_offs = torque[15] ? torque - MIN_DUTY : torque + MIN_DUTY;
  assign low_gain  = GAIN_MULT * torque;   // upper product bits dropped

  // small torques get extra gain, larger ones get the min duty kick
  assign shaped_nxt = (torque_mag >= LOW_BAND) ? duty_offs : low_gain;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shaped <= '0;
    end else begin
      shaped <= shaped_nxt;
    end
  end

endmodule

`default_nettype wire

/* design/pitch_integrator.sv */
// pitch error integrator
`timescale 1ns/1ps
`default_nettype none

module pitch_integrator
  import balance_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       vld,         // accumulate only on a new sample
  input  ptch_err_t ptch_err,    // saturated error from the PD unit
  input  wire       rider_off,   // no weight on the load cells
  input  wire       pwr_up,      // vehicle enabled
  output integ_t    integrator
);

  integ_t nxt_integ;    // candidate sum
  logic   pos_ovfl;
  logic   neg_ovfl;
  logic   ovfl;

  ////////////////////////////////////////
  // next value and overflow detect
  ////////////////////////////////////////

  assign nxt_integ = integrator + integ_t'(ptch_err);   // error sign extended

  // overflow only when both operands share a sign the sum does not keep
  assign pos_ovfl = ~integrator[17] & ~ptch_err[9] &  nxt_integ[17];
  assign neg_ovfl =  integrator[17] &  ptch_err[9] & ~nxt_integ[17];
  assign ovfl     = pos_ovfl | neg_ovfl;

  ////////////////////////////////////////
  // accumulator
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integrator <= '0;
    end else if (!pwr_up || rider_off) begin
      integrator <= '0;              // start fresh for the next ride
    end else if (vld && !ovfl) begin
      integrator <= nxt_integ;
    end
    // on overflow the value holds at its last good sum
  end

endmodule

`default_nettype wire

/* design/pitch_pd_term.sv */
// pitch proportional and derivative terms
`timescale 1ns/1ps
`default_nettype none

`include "balance_macros.svh"

module pitch_pd_term
  import balance_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire               vld,       // new pitch sample strobe
  input  wire signed [15:0] ptch,      // raw pitch reading
  output ptch_err_t         ptch_err,  // saturated error, combinational
  output p_term_t           p_term,    // registered P term
  output d_term_t           d_term     // registered D term
);

  localparam ptch_err_t ERR_MOST_NEG = 10'h200;
  localparam ptch_err_t ERR_MOST_POS = 10'h1FF;
  localparam logic signed [6:0] DIFF_MOST_NEG = 7'h40;
  localparam logic signed [6:0] DIFF_MOST_POS = 7'h3F;
  localparam p_term_t P_COEFF = `BAL_P_COEFF;
  localparam d_term_t D_COEFF = `BAL_D_COEFF;

  ptch_err_t              err_hist1;   // error one sample back
  ptch_err_t              err_hist2;   // error two samples back
  logic signed [9:0]      d_diff;      // wrapped difference
  logic signed [6:0]      d_diff_sat;

  ////////////////////////////////////////
  // error saturation and P term
  ////////////////////////////////////////

  // upper bits must all match the sign, otherwise clip to the 10 bit range
  assign ptch_err = ptch[15] ? (&ptch[15:9] ? ptch[9:0] : ERR_MOST_NEG)
                             : (|ptch[15:9] ? ERR_MOST_POS : ptch[9:0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p_term <= '0;
    end else begin
      p_term <= P_COEFF * ptch_err;   // sampled every edge, not only on vld
    end
  end

  ////////////////////////////////////////
  // sample history and D term
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_hist1 <= '0;
      err_hist2 <= '0;
    end else if (vld) begin
      err_hist1 <= ptch_err;
      err_hist2 <= err_hist1;   // shift on each new reading
    end
  end

  assign d_diff = ptch_err - err_hist2;   // wraps at 10 bits

  // clip to 7 bits signed
  assign d_diff_sat = d_diff[9] ? (&d_diff[9:6] ? d_diff[6:0] : DIFF_MOST_NEG)
                                : (|d_diff[9:6] ? DIFF_MOST_POS : d_diff[6:0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_term <= '0;
    end else begin
      d_term <= D_COEFF * d_diff_sat;
    end
  end

endmodule

`default_nettype wire

/* design/torque_mixer.sv */
// PID sum and steering mix
`timescale 1ns/1ps
`default_nettype none

`include "balance_macros.svh"

module torque_mixer
  import balance_pkg::*;
(
  input  p_term_t           p_term,
  input  d_term_t           d_term,
  input  integ_t            integrator,
  input  wire signed [11:0] ld_cell_diff,   // left minus right load
  input  wire               en_steer,
  output torque_t           lft_torque,
  output torque_t           rght_torque
);

  torque_t pid_cntrl;   // combined control value
  torque_t steer;       // scaled load cell difference
  torque_t cntrl_plus;
  torque_t cntrl_minus;

  ////////////////////////////////////////
  // PID sum
  ////////////////////////////////////////

  // every term sign extended to 16 bits, the I term scaled down by 64
  assign pid_cntrl = torque_t'(p_term) + torque_t'(d_term)
                   + torque_t'(integrator >>> `BAL_INT_SHIFT);

  ////////////////////////////////////////
  // steering
  ////////////////////////////////////////

  assign steer       = torque_t'(ld_cell_diff >>> `BAL_STEER_SHIFT);
  assign cntrl_plus  = pid_cntrl + steer;
  assign cntrl_minus = pid_cntrl - steer;

  // steer direction flips with the sign of the control value
  always_comb begin
    if (!en_steer) begin
      lft_torque  = pid_cntrl;
      rght_torque = pid_cntrl;
    end else if (pid_cntrl[15]) begin
      lft_torque  = cntrl_plus;
      rght_torque = cntrl_minus;
    end else begin
      lft_torque  = cntrl_minus;   // zero counts as positive
      rght_torque = cntrl_plus;
    end
  end

endmodule

`default_nettype wire

/* testbench/balance_checker.sv */
// balance controller reference checker
`timescale 1ns/1ps
`default_nettype none

`include "balance_macros.svh"

module balance_checker
  import balance_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire               vld,
  input  wire signed [15:0] ptch,
  input  wire signed [11:0] ld_cell_diff,
  input  wire               rider_off,
  input  wire               en_steer,
  input  wire               pwr_up,
  input  spd_t              lft_spd,
  input  wire               lft_rev,
  input  spd_t              rght_spd,
  input  wire               rght_rev,
  input  wire               ovr_spd,
  output int                err_cnt,     // running mismatch count
  output logic              hold_seen,   // model integrator held on the last edge
  output logic              sat_seen     // both model speeds at full scale
);

  localparam integer INT_MAX = 2 ** ($bits(integ_t) - 1) - 1;
  localparam integer INT_MIN = -(2 ** ($bits(integ_t) - 1));

  integer m_p;        // model registers, one per DUT register
  integer m_d;
  integer m_hist1;
  integer m_hist2;
  integer m_integ;
  integer m_lft_sh;
  integer m_rght_sh;

  function automatic integer clip(input integer v, input integer lo, input integer hi);
    if (v < lo) return lo;
    if (v > hi) return hi;
    return v;
  endfunction

  // keep the low bits of v, read back as signed
  function automatic integer wrap(input integer v, input integer bits);
    integer r;
    r = v & ((1 << bits) - 1);
    if (r >= (1 << (bits - 1))) r = r - (1 << bits);
    return r;
  endfunction

  // low band gets gain, the rest gets pushed out by the min duty
  function automatic integer shape(input integer t);
    integer mag;
    mag = (t < 0) ? -t : t;
    if (mag >= `BAL_LOW_TORQUE_BAND)
      return wrap((t < 0) ? t - `BAL_MIN_DUTY : t + `BAL_MIN_DUTY, 16);
    return wrap(t * `BAL_GAIN_MULT, 16);
  endfunction

  function automatic integer speed(input integer sh, input logic pwr);
    integer mag;
    mag = (sh < 0) ? -sh : sh;
    if (!pwr) return 0;   // gated off while powered down
    return clip(mag, 0, `BAL_SPD_MAX);
  endfunction

  task automatic check_val(input string name, input integer got, input integer exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR %0t ns: %s is %0d, model expects %0d", $time, name, got, exp);
    end
  endtask

  initial begin
    err_cnt   = 0;
    hold_seen = 1'b0;
    sat_seen  = 1'b0;
  end

  ////////////////////////////////////////
  // cycle model and compare
  ////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin : model_step
    integer err;
    integer diff;
    integer cntrl;
    integer steer;
    integer lft_t;
    integer rght_t;
    integer lft_exp;
    integer rght_exp;
    integer ovr_exp;
    if (!rst_n) begin
      m_p       = 0;
      m_d       = 0;
      m_hist1   = 0;
      m_hist2   = 0;
      m_integ   = 0;
      m_lft_sh  = 0;
      m_rght_sh = 0;
    end else begin
      // outputs are still those of the shaped values before this edge
      lft_exp  = speed(m_lft_sh, pwr_up);
      rght_exp = speed(m_rght_sh, pwr_up);
      ovr_exp  = (lft_exp > `BAL_WARN_SPD) || (rght_exp > `BAL_WARN_SPD);
      check_val("lft_spd", lft_spd, lft_exp);
      check_val("rght_spd", rght_spd, rght_exp);
      check_val("lft_rev", lft_rev, m_lft_sh < 0);
      check_val("rght_rev", rght_rev, m_rght_sh < 0);
      check_val("ovr_spd", ovr_spd, ovr_exp);
      sat_seen = (lft_exp == `BAL_SPD_MAX) && (rght_exp == `BAL_SPD_MAX);

      // mixer works on the old terms
      cntrl = wrap(m_p + m_d + (m_integ >>> `BAL_INT_SHIFT), 16);
      steer = ld_cell_diff;
      steer = steer >>> `BAL_STEER_SHIFT;
      if (!en_steer) begin
        lft_t  = cntrl;
        rght_t = cntrl;
      end else if (cntrl < 0) begin
        lft_t  = wrap(cntrl + steer, 16);
        rght_t = wrap(cntrl - steer, 16);
      end else begin
        lft_t  = wrap(cntrl - steer, 16);   // zero steers like positive
        rght_t = wrap(cntrl + steer, 16);
      end
      m_lft_sh  = shape(lft_t);
      m_rght_sh = shape(rght_t);

      // P and D from this edge's pitch
      err  = clip(ptch, -512, 511);
      diff = clip(wrap(err - m_hist2, 10), -64, 63);
      m_p  = `BAL_P_COEFF * err;
      m_d  = `BAL_D_COEFF * diff;

      hold_seen = 1'b0;
      if (!pwr_up || rider_off) begin
        m_integ = 0;
      end else if (vld) begin
        if (m_integ + err > INT_MAX || m_integ + err < INT_MIN) begin
          hold_seen = 1'b1;   // sum stays at its last value
        end else begin
          m_integ = m_integ + err;
        end
      end
      if (vld) begin
        m_hist2 = m_hist1;
        m_hist1 = err;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/balance_cntrl_tb.sv */
// balance controller testbench
`timescale 1ns/1ps
`default_nettype none

module balance_cntrl_tb
  import balance_pkg::*;
();

  localparam int          CLK_PERIOD   = 4;
  localparam int          RST_CYCLES   = 16;
  localparam int          FLAG_TIMEOUT = 1000;      // cycles
  localparam logic [15:0] LFSR_SEED    = 16'd7257;
  localparam logic [15:0] LFSR_TAPS    = 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1

  logic               clk;
  logic               rst_n;
  logic               vld;
  logic signed [15:0] ptch;
  logic signed [11:0] ld_cell_diff;
  logic               rider_off;
  logic               en_steer;
  logic               pwr_up;
  spd_t               lft_spd;
  spd_t               rght_spd;
  wire                lft_rev;
  wire                rght_rev;
  wire                ovr_spd;
  int                 err_cnt;
  logic               hold_seen;
  logic               sat_seen;
  logic [15:0]        lfsr;
  int                 tests_ok;
  int                 tests_bad;
  int                 err_base;   // mismatches before the current test

  balance_cntrl u_balance_cntrl (.*);

  balance_checker u_checker (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // random bits
  ////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);   // one step per bit
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  // n cycles of random vld and pitch, steer optional
  task automatic drive_random(input int n, input bit full_range, input bit steer_rand);
    logic [31:0] r;
    for (int c = 0; c < n; c++) begin
      @(negedge clk);
      take_bits(1, r);
      vld = r[0];
      take_bits(full_range ? 16 : 9, r);
      if (full_range) ptch = r[15:0];
      else if (r[8]) ptch = {{13{r[2]}}, r[2:0]};   // tiny, reaches the low band
      else ptch = {{8{r[7]}}, r[7:0]};
      if (steer_rand) begin
        take_bits(12, r);
        ld_cell_diff = r[11:0];
      end
    end
  endtask

  task automatic wait_model_flag(input bit want_sat, output bit ok);
    ok = 1'b0;
    for (int c = 0; c < FLAG_TIMEOUT && !ok; c++) begin
      @(negedge clk);
      ok = want_sat ? sat_seen : hold_seen;
    end
  endtask

  task automatic report_test(input string name, input bit extra_ok);
    int errs;
    repeat (3) @(negedge clk);   // let the two edge pipeline drain
    errs = err_cnt - err_base;
    err_base = err_cnt;
    if (errs == 0 && extra_ok) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: FAIL, %0d mismatches", name, errs);
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    bit ok;
    bit ok2;
    clk          = 1'b0;
    rst_n        = 1'b0;
    vld          = 1'b0;
    ptch         = '0;
    ld_cell_diff = '0;
    rider_off    = 1'b0;
    en_steer     = 1'b0;
    pwr_up       = 1'b1;
    lfsr         = LFSR_SEED;
    tests_ok     = 0;
    tests_bad    = 0;
    err_base     = 0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    report_test("reset", 1'b1);

    pwr_up = 1'b0;
    drive_random(40, 1'b1, 1'b0);
    pwr_up = 1'b1;
    drive_random(40, 1'b0, 1'b0);
    report_test("power-down gating", 1'b1);

    drive_random(200, 1'b0, 1'b0);
    report_test("balance without steering", 1'b1);

    en_steer = 1'b1;
    drive_random(200, 1'b0, 1'b1);
    report_test("steering", 1'b1);

    en_steer = 1'b0;
    vld      = 1'b1;
    ptch     = 16'h7FFF;   // far past the error clip
    wait_model_flag(1'b0, ok);
    if (!ok) $display("timeout: integrator never reached its hold point");
    wait_model_flag(1'b1, ok2);
    if (!ok2) $display("timeout: speeds never reached full scale");
    // freeze the held sum, the I term then shows below full scale
    vld  = 1'b0;
    ptch = '0;
    repeat (6) @(negedge clk);
    vld  = 1'b1;
    ptch = 16'h8000;
    repeat (20) @(negedge clk);
    report_test("saturation and warning", ok && ok2);

    rider_off = 1'b1;
    drive_random(5, 1'b0, 1'b0);
    rider_off = 1'b0;
    drive_random(100, 1'b0, 1'b0);
    report_test("rider-off clear", 1'b1);

    $display("tests ok: %0d, tests failing: %0d, mismatches: %0d", tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
